/* build.f */
+incdir+.
debug_pkg.sv
cmd_decoder.sv
run_control.sv
dump_sequencer.sv
byte_serializer.sv
debug_unit_top.sv
tb_debug_unit.sv

/* tb_debug_unit.sv */
`include "debug_macros.svh"

module tb_debug_unit;

    localparam int CLK_PERIOD      = 20;
    localparam int NUM_TESTS       = 5;
    localparam int DUMP_BYTES      = (2 + `DBG_NUM_REGS + `DBG_MEM_WORDS) * 4;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * DUMP_BYTES * 8 + 2000;

    logic                             clk;
    logic                             reset;
    logic                             i_rx_valid;
    logic [`DBG_BYTE_BITS-1:0]        i_rx_data;
    logic                             i_tx_ready;
    logic                             i_core_halt;
    logic [`DBG_WORD_BITS-1:0]        i_core_pc;
    logic [`DBG_WORD_BITS-1:0]        i_core_cycles;
    logic [`DBG_WORD_BITS-1:0]        i_reg_data;
    logic [`DBG_WORD_BITS-1:0]        i_mem_data;
    logic                             o_tx_valid;
    logic [`DBG_BYTE_BITS-1:0]        o_tx_data;
    logic                             o_core_run;
    logic                             o_core_reset;
    logic [$clog2(`DBG_NUM_REGS)-1:0] o_reg_sel;
    logic [`DBG_WORD_BITS-1:0]        o_mem_addr;
    logic                             o_instr_we;
    logic [`DBG_WORD_BITS-1:0]        o_instr_addr;
    logic [`DBG_WORD_BITS-1:0]        o_instr_data;

    logic [31:0] cycles     = '0;    // Core model cycle counter
    logic [31:0] halt_val   = 32'd1000;
    int          run_count  = 0;     // Negedges seen with o_core_run high
    logic        we_prev    = 1'b0;
    logic        we_twice   = 1'b0;
    logic [31:0] wr_addr_q[$];
    logic [31:0] wr_data_q[$];
    logic [31:0] rand_state = 32'd32;
    int          error_count  = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          test_first_error;

    debug_unit_top debug_unit_top_inst (
        .clk           (clk),
        .reset         (reset),
        .i_rx_valid    (i_rx_valid),
        .i_rx_data     (i_rx_data),
        .i_tx_ready    (i_tx_ready),
        .i_core_halt   (i_core_halt),
        .i_core_pc     (i_core_pc),
        .i_core_cycles (i_core_cycles),
        .i_reg_data    (i_reg_data),
        .i_mem_data    (i_mem_data),
        .o_tx_valid    (o_tx_valid),
        .o_tx_data     (o_tx_data),
        .o_core_run    (o_core_run),
        .o_core_reset  (o_core_reset),
        .o_reg_sel     (o_reg_sel),
        .o_mem_addr    (o_mem_addr),
        .o_instr_we    (o_instr_we),
        .o_instr_addr  (o_instr_addr),
        .o_instr_data  (o_instr_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Core model updated on the falling edge like all other inputs
    assign i_core_cycles = cycles;
    assign i_core_pc     = cycles << 2;
    assign i_core_halt   = (cycles == halt_val);
    assign i_reg_data    = 32'h1000_0000 + o_reg_sel;
    assign i_mem_data    = 32'hA000_0000 + o_mem_addr;

    always @(negedge clk) begin
        if (o_core_reset === 1'b1) begin
            cycles <= '0;
        end else if (o_core_run === 1'b1) begin
            cycles <= cycles + 32'd1;
        end
        if (o_core_run === 1'b1) begin
            run_count <= run_count + 1;
        end
        if (o_instr_we === 1'b1) begin  // Instruction memory write port
            wr_addr_q.push_back(o_instr_addr);
            wr_data_q.push_back(o_instr_data);
            if (we_prev) begin
                we_twice <= 1'b1;
            end
        end
        we_prev <= (o_instr_we === 1'b1);
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Word k of a dump in the order PC, cycles, registers and memory
    function automatic logic [31:0] expected_word(input int k, input logic [31:0] pc,
                                                  input logic [31:0] cyc);
        if (k == 0) begin
            return pc;
        end else if (k == 1) begin
            return cyc;
        end else if (k < 2 + `DBG_NUM_REGS) begin
            return 32'h1000_0000 + (k - 2);
        end
        return 32'hA000_0000 + 4 * (k - 2 - `DBG_NUM_REGS);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Fail %s: expected %h, actual %h", name, exp, act);
        error_count++;
    endtask

    task automatic report_problem(input string name, input string msg);
        $display("Error in %s: %s", name, msg);
        error_count++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (error_count == test_first_error) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, error_count - test_first_error);
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(negedge clk);
        i_rx_valid = 1'b1;
        i_rx_data  = b;
        @(negedge clk);
        i_rx_valid = 1'b0;
    endtask

    task automatic send_word(input logic [31:0] w);
        for (int i = 3; i >= 0; i--) begin
            send_byte(w[8*i +: 8]);  // Most significant byte first
        end
    endtask

    // Takes one dump under random back-pressure and checks every byte
    task automatic collect_dump(input string name, input logic [31:0] exp_pc,
                                input logic [31:0] exp_cyc);
        int          idx;
        logic [31:0] word;
        logic [7:0]  exp_byte;
        idx = 0;
        while (idx < DUMP_BYTES) begin
            @(negedge clk);
            rand_state = xorshift32(rand_state);
            i_tx_ready = rand_state[0];
            if (o_tx_valid === 1'b1 && i_tx_ready) begin  // Transfer at the next rising edge
                word     = expected_word(idx / 4, exp_pc, exp_cyc);
                exp_byte = word[8*(3 - idx % 4) +: 8];
                if (o_tx_data !== exp_byte) begin
                    report_mismatch(name, exp_byte, o_tx_data);
                end
                idx++;
            end
        end
        @(negedge clk);
        i_tx_ready = 1'b0;
    endtask

    task automatic wait_core_reset(input string name);
        int n;
        n = 0;
        while (o_core_reset !== 1'b1 && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (o_core_reset !== 1'b1) begin
            report_problem(name, "core not held in reset after the dump");
        end
    endtask

    task automatic test_reset_state();
        test_first_error = error_count;
        @(negedge clk);
        if (o_core_reset !== 1'b1) report_mismatch("reset o_core_reset", 1, o_core_reset);
        if (o_core_run !== 1'b0) report_mismatch("reset o_core_run", 0, o_core_run);
        if (o_tx_valid !== 1'b0) report_mismatch("reset o_tx_valid", 0, o_tx_valid);
        if (o_instr_we !== 1'b0) report_mismatch("reset o_instr_we", 0, o_instr_we);
        finish_test("reset_state");
    endtask

    task automatic test_load();
        logic [31:0] words [3];
        words = '{32'h1234_5678, 32'hCAFE_F00D, `DBG_LOAD_END};
        test_first_error = error_count;
        send_byte(`DBG_CMD_LOAD);
        for (int i = 0; i < 3; i++) begin
            send_word(words[i]);
        end
        repeat (4) @(negedge clk);
        if (wr_addr_q.size() != 3) begin
            report_mismatch("load write count", 3, wr_addr_q.size());
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (wr_addr_q[i] !== 4 * i) report_mismatch("load address", 4 * i, wr_addr_q[i]);
                if (wr_data_q[i] !== words[i]) report_mismatch("load data", words[i], wr_data_q[i]);
            end
        end
        if (we_twice) report_problem("load", "write strobe held for two cycles");
        if (o_instr_addr !== '0) report_mismatch("load address after end", 0, o_instr_addr);
        finish_test("load");
    endtask

    task automatic test_run();
        int base;
        test_first_error = error_count;
        halt_val = 32'd5;
        base     = run_count;
        send_byte(`DBG_CMD_RUN);
        collect_dump("run dump", 32'd20, 32'd5);
        wait_core_reset("run");
        if (run_count - base != 5) report_mismatch("run cycles", 5, run_count - base);
        finish_test("run");
    endtask

    task automatic test_step();
        int base;
        test_first_error = error_count;
        halt_val = 32'd2;  // Second step lands on the halt and ends step mode
        base     = run_count;
        send_byte(`DBG_CMD_STEP);
        repeat (3) @(negedge clk);
        if (o_core_reset !== 1'b0) report_mismatch("step o_core_reset", 0, o_core_reset);
        send_byte(`DBG_CMD_NEXT);
        collect_dump("step dump 1", 32'd4, 32'd1);
        if (run_count - base != 1) report_mismatch("step 1 run cycles", 1, run_count - base);
        repeat (4) @(negedge clk);  // Back in step wait one cycle after the dump ends
        send_byte(`DBG_CMD_NEXT);
        collect_dump("step dump 2", 32'd8, 32'd2);
        if (run_count - base != 2) report_mismatch("step 2 run cycles", 2, run_count - base);
        wait_core_reset("step");
        finish_test("step");
    endtask

    task automatic test_dropped_bytes();
        int base;
        test_first_error = error_count;
        halt_val = 32'd3;
        base     = run_count;
        send_byte(8'h78);  // Not a command
        repeat (20) begin
            @(negedge clk);
            if (o_tx_valid !== 1'b0) report_problem("dropped", "dump after unknown byte");
        end
        if (run_count != base) report_mismatch("dropped idle run cycles", 0, run_count - base);
        send_byte(`DBG_CMD_RUN);
        fork
            collect_dump("dropped dump", 32'd12, 32'd3);
            begin
                repeat (60) @(negedge clk);
                send_byte(`DBG_CMD_RUN);  // Arrives mid-dump
            end
        join
        wait_core_reset("dropped");
        i_tx_ready = 1'b1;
        repeat (40) begin
            @(negedge clk);
            if (o_tx_valid !== 1'b0) report_problem("dropped", "extra dump bytes sent");
        end
        if (run_count - base != 3) report_mismatch("dropped run cycles", 3, run_count - base);
        finish_test("dropped_bytes");
    endtask

    initial begin
        reset      = 1'b1;
        i_rx_valid = 1'b0;
        i_rx_data  = '0;
        i_tx_ready = 1'b0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        test_reset_state();
        test_load();
        test_run();
        test_step();
        test_dropped_bytes();
        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* debug_unit_top.sv */
`include "debug_macros.svh"

module debug_unit_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             i_rx_valid,
    input  logic [`DBG_BYTE_BITS-1:0]        i_rx_data,
    input  logic                             i_tx_ready,
    input  logic                             i_core_halt,
    input  logic [`DBG_WORD_BITS-1:0]        i_core_pc,
    input  logic [`DBG_WORD_BITS-1:0]        i_core_cycles,
    input  logic [`DBG_WORD_BITS-1:0]        i_reg_data,
    input  logic [`DBG_WORD_BITS-1:0]        i_mem_data,
    output logic                             o_tx_valid,
    output logic [`DBG_BYTE_BITS-1:0]        o_tx_data,
    output logic                             o_core_run,
    output logic                             o_core_reset,
    output logic [$clog2(`DBG_NUM_REGS)-1:0] o_reg_sel,
    output logic [`DBG_WORD_BITS-1:0]        o_mem_addr,
    output logic                             o_instr_we,
    output logic [`DBG_WORD_BITS-1:0]        o_instr_addr,
    output logic [`DBG_WORD_BITS-1:0]        o_instr_data
);
    import debug_pkg::*;

    logic      cmd_run;
    logic      cmd_step;
    logic      cmd_next;
    logic      idle;
    logic      step_wait;
    logic      dump_req;
    logic      dump_done;
    logic      word_valid;
    logic      word_ready;
    dbg_word_u seq_word;    // Sequencer to serializer
    dbg_word_u instr_word;  // Assembled program word

    cmd_decoder cmd_decoder_inst (
        .clk          (clk),
        .reset        (reset),
        .i_rx_valid   (i_rx_valid),
        .i_rx_data    (i_rx_data),
        .i_idle       (idle),
        .i_step_wait  (step_wait),
        .o_cmd_run    (cmd_run),
        .o_cmd_step   (cmd_step),
        .o_cmd_next   (cmd_next),
        .o_instr_we   (o_instr_we),
        .o_instr_addr (o_instr_addr),
        .o_instr_data (instr_word)
    );

    run_control run_control_inst (
        .clk          (clk),
        .reset        (reset),
        .i_cmd_run    (cmd_run),
        .i_cmd_step   (cmd_step),
        .i_cmd_next   (cmd_next),
        .i_core_halt  (i_core_halt),
        .i_dump_done  (dump_done),
        .o_core_run   (o_core_run),
        .o_core_reset (o_core_reset),
        .o_dump_req   (dump_req),
        .o_idle       (idle),
        .o_step_wait  (step_wait)
    );

    dump_sequencer dump_sequencer_inst (
        .clk           (clk),
        .reset         (reset),
        .i_dump_req    (dump_req),
        .i_core_pc     (i_core_pc),
        .i_core_cycles (i_core_cycles),
        .i_reg_data    (i_reg_data),
        .i_mem_data    (i_mem_data),
        .i_word_ready  (word_ready),
        .o_word_valid  (word_valid),
        .o_word        (seq_word),
        .o_reg_sel     (o_reg_sel),
        .o_mem_addr    (o_mem_addr),
        .o_dump_done   (dump_done)
    );

    byte_serializer byte_serializer_inst (
        .clk          (clk),
        .reset        (reset),
        .i_word_valid (word_valid),
        .i_word       (seq_word),
        .i_tx_ready   (i_tx_ready),
        .o_word_ready (word_ready),
        .o_tx_valid   (o_tx_valid),
        .o_tx_data    (o_tx_data)
    );

    assign o_instr_data = instr_word.word;  // Instruction memory takes the whole word

endmodule

/* byte_serializer.sv */
`include "debug_macros.svh"

module byte_serializer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      i_word_valid,
    input  debug_pkg::dbg_word_u      i_word,
    input  logic                      i_tx_ready,
    output logic                      o_word_ready,
    output logic                      o_tx_valid,
    output logic [`DBG_BYTE_BITS-1:0] o_tx_data
);
    import debug_pkg::*;

    localparam int CNT_BITS = $clog2(`DBG_WORD_BITS / `DBG_BYTE_BITS);

    dbg_word_u           hold_word;  // Word being sent
    logic [CNT_BITS-1:0] byte_cnt;   // Lane on the wire counting down
    logic                full;

    always_ff @(posedge clk) begin
        if (reset) begin
            full     <= 1'b0;
            byte_cnt <= '0;
        end else if (!full) begin
            if (i_word_valid) begin
                full     <= 1'b1;
                byte_cnt <= '1;  // Most significant lane first
            end
        end else if (i_tx_ready) begin
            if (byte_cnt == '0) begin
                full <= 1'b0;
            end else begin
                byte_cnt <= byte_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!full && i_word_valid) begin
            hold_word <= i_word;
        end
    end

    assign o_word_ready = !full;  // Only take a word when empty
    assign o_tx_valid   = full;
    assign o_tx_data    = hold_word.bytes[byte_cnt];

    a_tx_stable : assert property (@(posedge clk) disable iff (reset)
        (o_tx_valid && !i_tx_ready) |=> (o_tx_valid && $stable(o_tx_data)))
        else $error("transmit byte changed under back-pressure");

endmodule

/* dump_sequencer.sv */
`include "debug_macros.svh"

module dump_sequencer (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 i_dump_req,
    input  logic [`DBG_WORD_BITS-1:0]            i_core_pc,
    input  logic [`DBG_WORD_BITS-1:0]            i_core_cycles,
    input  logic [`DBG_WORD_BITS-1:0]            i_reg_data,
    input  logic [`DBG_WORD_BITS-1:0]            i_mem_data,
    input  logic                                 i_word_ready,
    output logic                                 o_word_valid,
    output debug_pkg::dbg_word_u                 o_word,
    output logic [$clog2(`DBG_NUM_REGS)-1:0]     o_reg_sel,
    output logic [`DBG_WORD_BITS-1:0]            o_mem_addr,
    output logic                                 o_dump_done
);
    import debug_pkg::*;

    localparam int REG_BITS = $clog2(`DBG_NUM_REGS);
    localparam int MEM_BITS = $clog2(`DBG_MEM_WORDS);

    localparam logic [2:0] PH_IDLE  = 3'd0;
    localparam logic [2:0] PH_PC    = 3'd1;
    localparam logic [2:0] PH_CYC   = 3'd2;
    localparam logic [2:0] PH_REG   = 3'd3;
    localparam logic [2:0] PH_MEM   = 3'd4;
    localparam logic [2:0] PH_DRAIN = 3'd5;  // Last word still in the serializer

    logic [2:0]                phase;
    logic [REG_BITS-1:0]       reg_idx;
    logic [MEM_BITS-1:0]       mem_idx;
    logic [`DBG_WORD_BITS-1:0] sample_word;
    logic                      load_word;
    logic                      accept;
    dbg_word_u                 word_q;

    always_comb begin
        case (phase)
            PH_PC:   sample_word = i_core_pc;
            PH_CYC:  sample_word = i_core_cycles;
            PH_REG:  sample_word = i_reg_data;
            default: sample_word = i_mem_data;
        endcase
    end

    assign load_word = !o_word_valid && (phase != PH_IDLE) && (phase != PH_DRAIN);
    assign accept    = o_word_valid && i_word_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase        <= PH_IDLE;
            o_word_valid <= 1'b0;
            reg_idx      <= '0;
            mem_idx      <= '0;
        end else begin
            if (load_word) begin
                o_word_valid <= 1'b1;
            end else if (accept) begin
                o_word_valid <= 1'b0;
            end
            case (phase)
                PH_IDLE: begin
                    if (i_dump_req) begin
                        phase <= PH_PC;
                    end
                end
                PH_PC: begin
                    if (accept) begin
                        phase <= PH_CYC;
                    end
                end
                PH_CYC: begin
                    if (accept) begin
                        phase <= PH_REG;
                    end
                end
                PH_REG: begin
                    if (accept) begin
                        reg_idx <= reg_idx + 1'b1;
                        if (reg_idx == REG_BITS'(`DBG_NUM_REGS - 1)) begin
                            phase <= PH_MEM;
                        end
                    end
                end
                PH_MEM: begin
                    if (accept) begin
                        mem_idx <= mem_idx + 1'b1;
                        if (mem_idx == MEM_BITS'(`DBG_MEM_WORDS - 1)) begin
                            phase <= PH_DRAIN;
                        end
                    end
                end
                default: begin
                    if (i_word_ready) begin
                        phase <= PH_IDLE;  // Serializer empty again
                    end
                end
            endcase
        end
    end

    // Core read captured once as the word is offered
    always_ff @(posedge clk) begin
        if (load_word) begin
            word_q.word <= sample_word;
        end
    end

    assign o_word      = word_q;
    assign o_reg_sel   = reg_idx;
    assign o_mem_addr  = {{(`DBG_WORD_BITS - MEM_BITS - 2){1'b0}}, mem_idx, 2'b00};  // Byte address
    assign o_dump_done = (phase == PH_DRAIN) && i_word_ready;

endmodule

/* run_control.sv */
module run_control (
    input  logic clk,
    input  logic reset,
    input  logic i_cmd_run,
    input  logic i_cmd_step,
    input  logic i_cmd_next,
    input  logic i_core_halt,
    input  logic i_dump_done,
    output logic o_core_run,
    output logic o_core_reset,
    output logic o_dump_req,
    output logic o_idle,
    output logic o_step_wait
);

    localparam logic [2:0] ST_IDLE       = 3'd0;
    localparam logic [2:0] ST_RUN        = 3'd1;
    localparam logic [2:0] ST_STEP_WAIT  = 3'd2;
    localparam logic [2:0] ST_STEP_PULSE = 3'd3;
    localparam logic [2:0] ST_DUMP       = 3'd4;

    logic [2:0] state;
    logic [2:0] state_next;
    logic       halt_seen;  // Set when the dump follows a halt

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (i_cmd_run) begin
                    state_next = ST_RUN;
                end else if (i_cmd_step) begin
                    state_next = ST_STEP_WAIT;
                end
            end
            ST_RUN: begin
                if (i_core_halt) begin
                    state_next = ST_DUMP;
                end
            end
            ST_STEP_WAIT: begin
                if (i_cmd_next) begin
                    state_next = ST_STEP_PULSE;
                end
            end
            ST_STEP_PULSE: state_next = ST_DUMP;  // Exactly one enabled core cycle
            ST_DUMP: begin
                if (i_dump_done) begin
                    state_next = (halt_seen || i_core_halt) ? ST_IDLE : ST_STEP_WAIT;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= ST_IDLE;
            o_core_run   <= 1'b0;
            o_core_reset <= 1'b1;
            o_dump_req   <= 1'b0;
            halt_seen    <= 1'b0;
        end else begin
            state        <= state_next;
            o_core_run   <= (state_next == ST_RUN) || (state_next == ST_STEP_PULSE);
            o_core_reset <= (state_next == ST_IDLE);  // Core stays out of reset through the dump
            o_dump_req   <= (state_next == ST_DUMP) && (state != ST_DUMP);
            if (state == ST_RUN) begin
                halt_seen <= 1'b1;  // Run mode only leaves on halt
            end else if (state == ST_STEP_PULSE) begin
                halt_seen <= 1'b0;
            end else if ((state == ST_DUMP) && i_core_halt) begin
                halt_seen <= 1'b1;  // Step landed on a halt
            end
        end
    end

    assign o_idle      = (state == ST_IDLE);
    assign o_step_wait = (state == ST_STEP_WAIT);

    a_run_not_in_reset : assert property (@(posedge clk) disable iff (reset)
        !(o_core_run && o_core_reset))
        else $error("core enabled while held in reset");

endmodule

/* cmd_decoder.sv */
`include "debug_macros.svh"

module cmd_decoder (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      i_rx_valid,
    input  logic [`DBG_BYTE_BITS-1:0] i_rx_data,
    input  logic                      i_idle,
    input  logic                      i_step_wait,
    output logic                      o_cmd_run,
    output logic                      o_cmd_step,
    output logic                      o_cmd_next,
    output logic                      o_instr_we,
    output logic [`DBG_WORD_BITS-1:0] o_instr_addr,
    output debug_pkg::dbg_word_u      o_instr_data
);
    import debug_pkg::*;

    logic       load_mode;  // Program bytes are expected
    logic [1:0] byte_idx;   // Bytes of the current word already taken
    dbg_word_u  asm_word;   // Word being assembled
    dbg_word_u  full_word;  // Word as it stands once the incoming byte lands in lane 0
    logic       cmd_byte;
    logic       load_byte;
    logic       last_byte;

    assign cmd_byte  = i_rx_valid && !load_mode && i_idle;
    assign load_byte = i_rx_valid && load_mode;
    assign last_byte = load_byte && (byte_idx == 2'd3);

    // Command pulses go out in the cycle the byte arrives
    assign o_cmd_run  = cmd_byte && (i_rx_data == `DBG_CMD_RUN);
    assign o_cmd_step = cmd_byte && (i_rx_data == `DBG_CMD_STEP);
    assign o_cmd_next = i_rx_valid && !load_mode && i_step_wait &&
                        (i_rx_data == `DBG_CMD_NEXT);

    always_comb begin
        full_word          = asm_word;
        full_word.bytes[0] = i_rx_data;  // Only meaningful on the fourth byte
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            load_mode    <= 1'b0;
            byte_idx     <= 2'd0;
            o_instr_we   <= 1'b0;
            o_instr_addr <= '0;
        end else begin
            o_instr_we <= last_byte;  // Write strobe in the cycle after the word completes
            if (load_byte) begin
                byte_idx <= byte_idx + 2'd1;
            end
            if (cmd_byte && (i_rx_data == `DBG_CMD_LOAD)) begin
                load_mode <= 1'b1;
            end else if (last_byte && (full_word.word == `DBG_LOAD_END)) begin
                load_mode <= 1'b0;  // Terminator still gets written
            end
            // Load mode already dropped during the terminator write
            if (o_instr_we) begin
                o_instr_addr <= load_mode ? o_instr_addr + 'd4 : '0;
            end
        end
    end

    // Big-endian placement with the first byte in lane 3
    always_ff @(posedge clk) begin
        if (load_byte) begin
            asm_word.bytes[2'd3 - byte_idx] <= i_rx_data;
        end
    end

    assign o_instr_data = asm_word;

    // A word is never written twice in a row
    a_single_write : assert property (@(posedge clk) disable iff (reset)
        o_instr_we |=> !o_instr_we)
        else $error("instruction write held for two cycles");

endmodule

/* debug_pkg.sv */
`include "debug_macros.svh"

package debug_pkg;

    // One core word seen either whole or as four bytes with index 3 the MSB
    typedef union packed {
        logic [`DBG_WORD_BITS-1:0] word;  // Whole word for core ports
        logic [`DBG_WORD_BITS/`DBG_BYTE_BITS-1:0][`DBG_BYTE_BITS-1:0] bytes;  // Byte lanes
    } dbg_word_u;

endpackage

/* debug_macros.svh */
`ifndef DEBUG_MACROS_SVH
`define DEBUG_MACROS_SVH

// Core and UART widths
`define DBG_WORD_BITS 32
`define DBG_BYTE_BITS 8

// Extent of a state dump
`define DBG_NUM_REGS  32
`define DBG_MEM_WORDS 16

// Command characters r, s, l and n
`define DBG_CMD_RUN  8'h72
`define DBG_CMD_STEP 8'h73
`define DBG_CMD_LOAD 8'h6c
`define DBG_CMD_NEXT 8'h6e

// Terminator word of a program load that is also written to memory
`define DBG_LOAD_END {`DBG_WORD_BITS{1'b1}}

`endif
